// ==== src/cpu_types_pkg.sv ====
package cpu_types_pkg;

    typedef logic [31:0] word_t;    // Data or address word
    typedef logic [4:0]  reg_idx_t; // Register file index

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    typedef struct packed {
        word_t     alu_result;    // Address for loads and stores
        word_t     store_data;
        logic      mem_read;
        logic      mem_write;
        mem_size_e size;
        logic      is_unsigned;   // Zero-extend narrow loads
        logic      mem_to_reg;
        logic      reg_write;
        reg_idx_t  reg_dest;
        logic      pc_src;
        word_t     branch_target;
    } ex_mem_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    load_data;      // Zero unless a load
        logic     mem_to_reg;
        logic     reg_write;
        reg_idx_t reg_dest;
        logic     pc_src;
        word_t    branch_target;
        logic     fault;          // Bus error on this access
    } mem_wb_t;

endpackage

// ==== src/axi_lite_pkg.sv ====
package axi_lite_pkg;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t resp_okay_c   = 2'b00;
    localparam axil_resp_t resp_slverr_c = 2'b10;

    // Master to slave
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

endpackage

// ==== src/mem_store_align.sv ====
`timescale 1ns/1ps

module mem_store_align (
    input  cpu_types_pkg::ex_mem_t    held,
    output cpu_types_pkg::word_t      wdata,
    output axi_lite_pkg::axil_strb_t  wstrb
);

    logic aligned;

    // Narrow stores are replicated so every lane carries the data
    always_comb
    begin
        unique case (held.size)
            cpu_types_pkg::size_byte:
            begin
                wdata = {4{held.store_data[7:0]}};
                wstrb = 4'b0001 << held.alu_result[1:0];   // One lane by low bits
            end
            cpu_types_pkg::size_half:
            begin
                wdata = {2{held.store_data[15:0]}};
                wstrb = held.alu_result[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                wdata = held.store_data;
                wstrb = 4'b1111;
            end
        endcase
    end

    always_comb
    begin
        unique case (held.size)
            cpu_types_pkg::size_half: aligned = (held.alu_result[0] == 1'b0);
            cpu_types_pkg::size_word: aligned = (held.alu_result[1:0] == 2'b00);
            default:                  aligned = 1'b1;
        endcase
    end

    // Stores must be naturally aligned
    always_comb
    begin
        if (held.mem_write)
        begin
            assert (aligned)
                else $error("Misaligned store at address %h", held.alu_result);
        end
    end

endmodule

// ==== src/mem_load_align.sv ====
`timescale 1ns/1ps

module mem_load_align (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_types_pkg::ex_mem_t held,
    input  cpu_types_pkg::word_t   rdata,
    input  logic                   done,
    input  logic                   fault,
    output logic                   wb_valid,
    output cpu_types_pkg::mem_wb_t mem_wb
);

    cpu_types_pkg::word_t   lane_data;
    cpu_types_pkg::word_t   ext_data;
    cpu_types_pkg::mem_wb_t next_wb;

    assign lane_data = rdata >> {held.alu_result[1:0], 3'b000};   // Addressed lane to bit 0

    always_comb
    begin
        unique case (held.size)
            cpu_types_pkg::size_byte:
                ext_data = held.is_unsigned ? {24'b0, lane_data[7:0]}
                                            : {{24{lane_data[7]}}, lane_data[7:0]};
            cpu_types_pkg::size_half:
                ext_data = held.is_unsigned ? {16'b0, lane_data[15:0]}
                                            : {{16{lane_data[15]}}, lane_data[15:0]};
            default:
                ext_data = rdata;
        endcase
    end

    always_comb
    begin
        next_wb.alu_result    = held.alu_result;
        next_wb.load_data     = held.mem_read ? ext_data : '0;
        next_wb.mem_to_reg    = held.mem_to_reg;
        next_wb.reg_write     = held.reg_write;
        next_wb.reg_dest      = held.reg_dest;
        next_wb.pc_src        = held.pc_src;
        next_wb.branch_target = held.branch_target;
        next_wb.fault         = fault;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid <= 1'b0;
            mem_wb   <= '0;
        end
        else
        begin
            wb_valid <= done;        // One-cycle pulse per result
            if (done)
            begin
                mem_wb <= next_wb;
            end
        end
    end

endmodule

// ==== src/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  cpu_types_pkg::ex_mem_t   ex_mem,
    output logic                     stall,
    output cpu_types_pkg::ex_mem_t   held,
    input  cpu_types_pkg::word_t     wdata,
    input  axi_lite_pkg::axil_strb_t wstrb,
    output axi_lite_pkg::axil_req_t  axil_req,
    input  axi_lite_pkg::axil_rsp_t  axil_rsp,
    output logic                     done,
    output logic                     fault
);

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_write_resp,
        st_read,
        st_read_resp
    } state_e;

    state_e state;
    logic   accept;
    logic   aw_done;       // Address phase finished
    logic   w_done;        // Data phase finished
    logic   aw_hs;
    logic   w_hs;
    logic   b_hs;
    logic   r_hs;
    logic   pass_done;     // Non-memory op completes

    assign stall  = (state != st_idle);
    assign accept = in_valid && !stall;

    assign aw_hs = axil_req.awvalid && axil_rsp.awready;
    assign w_hs  = axil_req.wvalid && axil_rsp.wready;
    assign b_hs  = axil_req.bready && axil_rsp.bvalid;
    assign r_hs  = axil_req.rready && axil_rsp.rvalid;

    always_comb
    begin
        axil_req.awaddr  = held.alu_result;
        axil_req.awvalid = (state == st_write) && !aw_done;
        axil_req.wdata   = wdata;
        axil_req.wstrb   = wstrb;
        axil_req.wvalid  = (state == st_write) && !w_done;
        axil_req.bready  = (state == st_write_resp);
        axil_req.araddr  = held.alu_result;
        axil_req.arvalid = (state == st_read);
        axil_req.rready  = (state == st_read_resp);
    end

    assign done  = pass_done || b_hs || r_hs;
    assign fault = (b_hs && (axil_rsp.bresp != axi_lite_pkg::resp_okay_c)) ||
                   (r_hs && (axil_rsp.rresp != axi_lite_pkg::resp_okay_c));

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            held <= ex_mem;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= st_idle;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            pass_done <= 1'b0;
        end
        else
        begin
            pass_done <= accept && !ex_mem.mem_read && !ex_mem.mem_write;
            unique case (state)
                st_idle:
                begin
                    if (accept && ex_mem.mem_write)
                        state <= st_write;      // Store wins if both set
                    else if (accept && ex_mem.mem_read)
                        state <= st_read;
                end
                st_write:
                begin
                    if ((aw_done || aw_hs) && (w_done || w_hs))
                    begin
                        state   <= st_write_resp;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                    else
                    begin
                        aw_done <= aw_done || aw_hs;
                        w_done  <= w_done || w_hs;
                    end
                end
                st_write_resp:
                    if (b_hs) state <= st_idle;
                st_read:
                    if (axil_rsp.arready) state <= st_read_resp;
                st_read_resp:
                    if (r_hs) state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // AXI valids hold until accepted
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        axil_req.awvalid && !axil_rsp.awready |=> axil_req.awvalid);
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        axil_req.wvalid && !axil_rsp.wready |=> axil_req.wvalid);
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        axil_req.arvalid && !axil_rsp.arready |=> axil_req.arvalid);

    // A response handshake returns the FSM to idle
    a_stall_release: assert property (@(posedge clk) disable iff (rst)
        stall && done |=> (state == st_idle));

endmodule

// ==== src/data_ram_axil.sv ====
`timescale 1ns/1ps

module data_ram_axil #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_WAIT  = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_lite_pkg::axil_req_t axil_req,
    output axi_lite_pkg::axil_rsp_t axil_rsp
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam int CNT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

    axi_lite_pkg::axil_data_t mem [RAM_WORDS];
    axi_lite_pkg::axil_data_t rdata_q;
    axi_lite_pkg::axil_resp_t bresp_q;
    axi_lite_pkg::axil_resp_t rresp_q;
    logic                     bvalid_q;
    logic                     rvalid_q;
    logic [CNT_W-1:0]         wait_cnt;
    logic                     wait_done;
    logic                     wr_req;
    logic                     rd_req;
    logic                     wr_go;          // Write accepted this cycle
    logic                     rd_go;          // Read accepted this cycle
    logic                     wr_in_range;
    logic                     rd_in_range;
    logic [IDX_W-1:0]         wr_idx;
    logic [IDX_W-1:0]         rd_idx;

    assign wr_req    = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_req    = axil_req.arvalid && !rvalid_q && !wr_req;
    assign wait_done = (wait_cnt == CNT_W'(RAM_WAIT));
    assign wr_go     = wr_req && wait_done;
    assign rd_go     = rd_req && wait_done;

    assign wr_in_range = ({2'b00, axil_req.awaddr[31:2]} < 32'(RAM_WORDS));
    assign rd_in_range = ({2'b00, axil_req.araddr[31:2]} < 32'(RAM_WORDS));
    assign wr_idx      = axil_req.awaddr[IDX_W+1:2];
    assign rd_idx      = axil_req.araddr[IDX_W+1:2];

    always_comb
    begin
        axil_rsp.awready = wr_go;   // Address and data taken together
        axil_rsp.wready  = wr_go;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.arready = rd_go;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rvalid  = rvalid_q;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wait_cnt <= '0;
            bvalid_q <= 1'b0;
            bresp_q  <= axi_lite_pkg::resp_okay_c;
            rvalid_q <= 1'b0;
            rresp_q  <= axi_lite_pkg::resp_okay_c;
        end
        else
        begin
            if (wr_go || rd_go || !(wr_req || rd_req))
                wait_cnt <= '0;
            else
                wait_cnt <= wait_cnt + 1'b1;

            if (wr_go)
            begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_in_range ? axi_lite_pkg::resp_okay_c
                                        : axi_lite_pkg::resp_slverr_c;
            end
            else if (axil_req.bready)
                bvalid_q <= 1'b0;

            if (rd_go)
            begin
                rvalid_q <= 1'b1;
                rresp_q  <= rd_in_range ? axi_lite_pkg::resp_okay_c
                                        : axi_lite_pkg::resp_slverr_c;
            end
            else if (axil_req.rready)
                rvalid_q <= 1'b0;
        end
    end

    // Storage and read data
    always_ff @(posedge clk)
    begin
        if (wr_go && wr_in_range)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (axil_req.wstrb[i])
                    mem[wr_idx][8*i +: 8] <= axil_req.wdata[8*i +: 8];
            end
        end
        if (rd_go)
            rdata_q <= rd_in_range ? mem[rd_idx] : '0;   // Out of range reads as zero
    end

endmodule

// ==== src/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top #(
    parameter int RAM_WORDS = 256,
    parameter int RAM_WAIT  = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  cpu_types_pkg::ex_mem_t ex_mem,
    output logic                   stall,
    output logic                   wb_valid,
    output cpu_types_pkg::mem_wb_t mem_wb
);

    cpu_types_pkg::ex_mem_t   held;
    cpu_types_pkg::word_t     wdata;
    axi_lite_pkg::axil_strb_t wstrb;
    axi_lite_pkg::axil_req_t  axil_req;
    axi_lite_pkg::axil_rsp_t  axil_rsp;
    logic                     done;
    logic                     fault;

    mem_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .ex_mem   (ex_mem),
        .stall    (stall),
        .held     (held),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .done     (done),
        .fault    (fault)
    );

    mem_store_align u_store (
        .held  (held),
        .wdata (wdata),
        .wstrb (wstrb)
    );

    mem_load_align u_load (
        .clk      (clk),
        .rst      (rst),
        .held     (held),
        .rdata    (axil_rsp.rdata),
        .done     (done),
        .fault    (fault),
        .wb_valid (wb_valid),
        .mem_wb   (mem_wb)
    );

    data_ram_axil #(
        .RAM_WORDS (RAM_WORDS),
        .RAM_WAIT  (RAM_WAIT)
    ) u_ram (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

endmodule

// ==== dv/mem_stage_checker.sv ====
`timescale 1ns/1ps

module mem_stage_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   wb_valid,
    input  cpu_types_pkg::mem_wb_t mem_wb,
    output int                     n_expected,
    output int                     n_seen,
    output int                     n_errors
);

    cpu_types_pkg::mem_wb_t exp_q[$];   // Expected results in input order
    logic                   stall_q;    // Stall one cycle earlier

    task automatic load_expectations();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] kind;
        logic [31:0] size;
        logic [31:0] uns;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] exp_data;
        logic [31:0] exp_fault;
        cpu_types_pkg::mem_wb_t wb;
        fd = $fopen("dv/mem_stage_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Checker cannot open the pattern file");
            n_errors++;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h",
                         kind, size, uns, addr, data, rd, exp_data, exp_fault);
            if (rc == 8)
            begin
                wb               = '0;
                wb.alu_result    = addr;
                wb.load_data     = exp_data;
                wb.mem_to_reg    = (kind == 1);
                wb.reg_write     = (kind != 2) && (rd != 0);   // Stores and x0 write nothing
                wb.reg_dest      = rd[4:0];
                wb.pc_src        = (kind == 0) && (data != 0);
                wb.branch_target = (kind == 0) ? data : '0;   // Data column is the target
                wb.fault         = exp_fault[0];
                exp_q.push_back(wb);
            end
        end
        $fclose(fd);
        n_expected = exp_q.size();
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH result %0d %s expected %h actual %h",
                     n_seen, name, expected, actual);
            n_errors++;
        end
    endtask

    task automatic check_result(input cpu_types_pkg::mem_wb_t exp);
        compare_field("alu_result", exp.alu_result, mem_wb.alu_result);
        compare_field("load_data", exp.load_data, mem_wb.load_data);
        compare_field("mem_to_reg", 32'(exp.mem_to_reg), 32'(mem_wb.mem_to_reg));
        compare_field("reg_write", 32'(exp.reg_write), 32'(mem_wb.reg_write));
        compare_field("reg_dest", 32'(exp.reg_dest), 32'(mem_wb.reg_dest));
        compare_field("pc_src", 32'(exp.pc_src), 32'(mem_wb.pc_src));
        compare_field("branch_target", exp.branch_target, mem_wb.branch_target);
        compare_field("fault", 32'(exp.fault), 32'(mem_wb.fault));
    endtask

    initial
    begin
        n_expected = 0;
        n_seen     = 0;
        n_errors   = 0;
        stall_q    = 1'b0;
        load_expectations();
        forever
        begin
            @(negedge clk);   // Registered outputs settled here
            if (rst)
            begin
                if (stall !== 1'b0 || wb_valid !== 1'b0 || mem_wb !== '0)
                begin
                    $display("Stage outputs are not cleared while reset is held");
                    n_errors++;
                end
            end
            else
            begin
                // Stall ends together with the writeback pulse
                if (stall_q && !stall && !wb_valid)
                begin
                    $display("Stall dropped without a writeback result");
                    n_errors++;
                end
                if (wb_valid)
                begin
                    if (exp_q.size() == 0)
                    begin
                        $display("Extra result with alu_result %h beyond the expected list",
                                 mem_wb.alu_result);
                        n_errors++;
                    end
                    else
                    begin
                        check_result(exp_q.pop_front());
                    end
                    n_seen++;
                end
            end
            stall_q = stall;
        end
    end

endmodule

// ==== dv/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int RAM_WORDS = 256;
    localparam int RAM_WAIT  = 2;
    localparam int MARGIN    = 40;   // Reset and drain cycles

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    cpu_types_pkg::ex_mem_t ex_mem;
    logic                   stall;
    logic                   wb_valid;
    cpu_types_pkg::mem_wb_t mem_wb;
    int                     n_expected;
    int                     n_seen;
    int                     n_errors;
    cpu_types_pkg::ex_mem_t ops_q[$];

    mem_stage_top #(
        .RAM_WORDS (RAM_WORDS),
        .RAM_WAIT  (RAM_WAIT)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .ex_mem   (ex_mem),
        .stall    (stall),
        .wb_valid (wb_valid),
        .mem_wb   (mem_wb)
    );

    mem_stage_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .wb_valid   (wb_valid),
        .mem_wb     (mem_wb),
        .n_expected (n_expected),
        .n_seen     (n_seen),
        .n_errors   (n_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic read_patterns();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] kind;
        logic [31:0] size;
        logic [31:0] uns;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] exp_data;
        logic [31:0] exp_fault;
        cpu_types_pkg::ex_mem_t op;
        fd = $fopen("dv/mem_stage_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Testbench cannot open the pattern file");
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            rc = $sscanf(line, "%h %h %h %h %h %h %h %h",
                         kind, size, uns, addr, data, rd, exp_data, exp_fault);
            if (rc == 8)
            begin
                op               = '0;
                op.alu_result    = addr;
                op.store_data    = (kind == 2) ? data : '0;
                op.mem_read      = (kind == 1);
                op.mem_write     = (kind == 2);
                op.size          = cpu_types_pkg::mem_size_e'(size[1:0]);
                op.is_unsigned   = uns[0];
                op.mem_to_reg    = (kind == 1);
                op.reg_write     = (kind != 2) && (rd != 0);
                op.reg_dest      = rd[4:0];
                op.pc_src        = (kind == 0) && (data != 0);
                op.branch_target = (kind == 0) ? data : '0;
                ops_q.push_back(op);
            end
        end
        $fclose(fd);
    endtask

    // Holds the bundle until an edge with stall low takes it
    task automatic send_op(input cpu_types_pkg::ex_mem_t op);
        in_valid = 1'b1;
        ex_mem   = op;
        @(negedge clk);
        while (stall)
            @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        ex_mem   = '0;
    endtask

    function automatic void report_counts();
        $display("Results seen %0d of %0d expected, errors %0d", n_seen, n_expected, n_errors);
    endfunction

    task automatic watchdog(input int limit);
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles while waiting for results", limit);
        report_counts();
        $display("Verification failed");
        $finish;
    endtask

    initial
    begin
        int gap;
        int limit;
        rst      = 1'b1;
        in_valid = 1'b0;
        ex_mem   = '0;
        void'($urandom(83));
        read_patterns();
        limit = ops_q.size() * (RAM_WAIT + 8) + MARGIN;
        fork
            watchdog(limit);
        join_none
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (ops_q[i])
        begin
            send_op(ops_q[i]);
            gap = $urandom % 4;   // Zero gives back-to-back ops
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
        end
        while (n_seen < n_expected)
            @(negedge clk);
        repeat (4) @(negedge clk);   // Room for a stray extra result
        report_counts();
        if (n_errors == 0 && n_seen == n_expected && ops_q.size() > 0 &&
            n_expected == ops_q.size())
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== dv/mem_stage_patterns.txt ====
# kind size uns addr data rd expect fault, every field in hex
# kind 0 alu 1 load 2 store; size 0 byte 1 half 2 word; data is branch target for alu
0 2 0 12345678 00000000 01 00000000 0
0 2 0 00000040 00000200 00 00000000 0
2 2 0 00000010 deadbeef 00 00000000 0
1 2 0 00000010 00000000 03 deadbeef 0
2 2 0 00000020 00000000 00 00000000 0
2 0 0 00000020 00000011 00 00000000 0
2 0 0 00000021 000000a2 00 00000000 0
2 1 0 00000022 00008033 00 00000000 0
1 2 0 00000020 00000000 04 8033a211 0
1 0 0 00000021 00000000 05 ffffffa2 0
1 0 1 00000021 00000000 06 000000a2 0
1 0 0 00000020 00000000 07 00000011 0
1 1 0 00000022 00000000 08 ffff8033 0
1 1 1 00000022 00000000 09 00008033 0
1 1 0 00000020 00000000 0a ffffa211 0
1 0 1 00000023 00000000 0b 00000080 0
0 2 0 0000abcd 00000100 1f 00000000 0
2 2 0 00000400 cafef00d 00 00000000 1
1 2 0 00000400 00000000 0c 00000000 1
1 2 0 00000010 00000000 0d deadbeef 0
2 2 0 000003fc 89abcdef 00 00000000 0
1 0 0 000003fe 00000000 0e ffffffab 0
1 1 1 000003fc 00000000 0f 0000cdef 0
1 0 0 00001001 00000000 10 00000000 1
0 2 0 00000ffc 00000000 11 00000000 0

// ==== verilog.f ====
src/cpu_types_pkg.sv
src/axi_lite_pkg.sv
src/mem_store_align.sv
src/mem_load_align.sv
src/mem_ctrl.sv
src/data_ram_axil.sv
src/mem_stage_top.sv
dv/mem_stage_checker.sv
dv/tb_mem_stage.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP      = tb_mem_stage
FILELIST = verilog.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD)
